// ==== rtl/knight_pkg.sv ====
package knight_pkg;

  ////////////////////
  // Field types.
  ////////////////////
  typedef logic [7:0] move_t;    // One-hot knight move, bit 0 is N2/E1.
  typedef logic [7:0] heading_t; // Heading code as sent to the executor.
  typedef logic [3:0] opcode_t;  // Command opcode.
  typedef logic [3:0] sq_cnt_t;  // Squares to travel on one leg.
  typedef logic [7:0] resp_t;    // Response byte back to the host.
  typedef logic [2:0] coord_t;   // Board coordinate, 0 to 4.

  // One command word, opcode in the top nibble.
  typedef struct packed {
    opcode_t  opcode;
    heading_t heading;
    sq_cnt_t  squares;
  } cmd_t;

  ////////////////////
  // Headings.
  ////////////////////
  localparam heading_t HDG_NORTH = 8'h00;
  localparam heading_t HDG_WEST  = 8'h3F;
  localparam heading_t HDG_SOUTH = 8'h7F;
  localparam heading_t HDG_EAST  = 8'hBF;

  ////////////////////
  // Opcodes.
  ////////////////////
  localparam opcode_t OP_HOME    = 4'h2; // Put the knight back on the centre square.
  localparam opcode_t OP_MOVE    = 4'h4; // Plain move.
  localparam opcode_t OP_MOVE_FF = 4'h5; // Move, then fanfare.

  // Responses.
  localparam resp_t RESP_BUSY = 8'h5A; // Command done, tour still going or none run.
  localparam resp_t RESP_DONE = 8'hA5; // Tour finished.

  // Board limits on a 5x5 board.
  localparam coord_t BOARD_MAX  = 3'd4;
  localparam coord_t HOME_COORD = 3'd2;

endpackage

// ==== rtl/move_store.sv ====
`timescale 1ns/1ps

module move_store #(
  parameter  int NUM_MOVES = 24,
  localparam int IDX_W     = $clog2(NUM_MOVES)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,   // Host write strobe.
  input  logic [IDX_W-1:0]  wr_addr, // Move slot to write.
  input  knight_pkg::move_t wr_data, // One-hot move to store.
  input  logic [IDX_W-1:0]  mv_indx, // Read index from the sequencer.
  output knight_pkg::move_t move     // Move at mv_indx, no read latency.
);

  import knight_pkg::*;

  ////////////////////
  // Storage.
  ////////////////////
  move_t mem [NUM_MOVES]; // One entry per tour move.
  logic  wr_ok;           // Write lands inside the array.

  assign wr_ok = wr_en && (int'(wr_addr) < NUM_MOVES);

  // Empty slots read as N2/E1 so the sequencer always sees a legal move.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_MOVES; i++) begin
        mem[i] <= move_t'(8'h01);
      end
    end else if (wr_ok) begin
      mem[wr_addr] <= wr_data; // Host load.
    end
  end

  ////////////////////
  // Read port.
  ////////////////////
  // Combinational read. Sequencer indexes stay below NUM_MOVES.
  assign move = mem[mv_indx];

endmodule

// ==== rtl/host_cmd_reg.sv ====
`timescale 1ns/1ps

module host_cmd_reg (
  input  logic             clk,
  input  logic             rst_n,
  input  knight_pkg::cmd_t host_cmd,     // Parallel command from the host.
  input  logic             host_cmd_vld, // One-cycle strobe with host_cmd.
  input  logic             clr_cmd_rdy,  // Executor has taken the command.
  output knight_pkg::cmd_t cmd_uart,     // Held command.
  output logic             cmd_rdy_uart  // High while a command is pending.
);

  ////////////////////
  // Capture.
  ////////////////////
  logic accept; // Strobe seen with nothing pending.

  // Only one command is held, a strobe while pending is lost.
  assign accept = host_cmd_vld && !cmd_rdy_uart;

  // Ready level.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cmd_rdy_uart <= 1'b0;
    end else if (clr_cmd_rdy) begin
      cmd_rdy_uart <= 1'b0; // Taken by the executor.
    end else if (accept) begin
      cmd_rdy_uart <= 1'b1; // Up the cycle after the strobe.
    end
  end

  // Command word, stable while pending and on through execution.
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_uart <= host_cmd;
    end
  end

endmodule

// ==== rtl/tour_cmd.sv ====
`timescale 1ns/1ps

module tour_cmd #(
  parameter  int NUM_MOVES = 24,
  localparam int IDX_W     = $clog2(NUM_MOVES)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_tour,   // Pulse, replay the stored tour.
  input  knight_pkg::move_t move,         // One-hot move at mv_indx.
  output logic [IDX_W-1:0]  mv_indx,      // Index of the move being played.
  input  knight_pkg::cmd_t  cmd_uart,     // Host command.
  input  logic              cmd_rdy_uart, // Host command pending.
  output knight_pkg::cmd_t  cmd,          // Command to the executor.
  output logic              cmd_rdy,      // Ready level to the executor.
  input  logic              clr_cmd_rdy,  // Executor took the command.
  output logic              clr_cmd_uart, // Clear routed back to the host register.
  input  logic              send_resp,    // Executor finished the command.
  output knight_pkg::resp_t resp          // Response byte.
);

  import knight_pkg::*;

  typedef enum logic [2:0] {IDLE, VERT, HOLDV, HORZ, HOLDH} state_t;

  state_t   state;        // Current state.
  state_t   nxt_state;    // Next state.
  logic     cmd_control;  // Tour owns the command path.
  logic     clr_index;    // Restart at move 0.
  logic     inc_index;    // Step to the next move.
  logic     tour_done;    // On the last move.
  logic     cmd_rdy_tour; // Tour command waiting for the executor.
  logic     horz_leg;     // Second leg of the L.
  logic     move_ok;      // Stored move is one-hot.
  logic     vert_north;   // Vertical leg heads north.
  logic     vert_two;     // Vertical leg is two squares.
  logic     horz_east;    // Horizontal leg heads east.
  heading_t leg_hdg;      // Heading of the current leg.
  sq_cnt_t  leg_sq;       // Squares on the current leg.
  cmd_t     cmd_tour;     // Command built from the move.

  ////////////////////
  // Move index.
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mv_indx <= '0;
    end else if (clr_index) begin
      mv_indx <= '0;              // New tour.
    end else if (inc_index) begin
      mv_indx <= mv_indx + 1'b1;  // Next move.
    end
  end

  assign tour_done = (mv_indx == IDX_W'(NUM_MOVES - 1)); // Stays set after the tour.

  ////////////////////
  // Move decode.
  ////////////////////
  // Vertical leg first, then the horizontal leg with fanfare.
  assign move_ok    = $onehot(move);
  assign vert_north = move[0] | move[1] | move[2] | move[7]; // N2/E1 N2/W1 N1/W2 N1/E2.
  assign vert_two   = move[0] | move[1] | move[4] | move[5]; // Two squares up or down.
  assign horz_east  = move[0] | move[5] | move[6] | move[7]; // Ends to the east.
  assign horz_leg   = (state == HORZ) || (state == HOLDH);

  always_comb begin
    if (horz_leg) begin
      leg_hdg = horz_east ? HDG_EAST : HDG_WEST;
      leg_sq  = vert_two ? 4'd1 : 4'd2; // Short side when the long side was vertical.
    end else begin
      leg_hdg = vert_north ? HDG_NORTH : HDG_SOUTH;
      leg_sq  = vert_two ? 4'd2 : 4'd1;
    end
    if (!move_ok) begin
      leg_sq = 4'd0; // Corrupt entry, stand still.
    end
  end

  assign cmd_tour = '{opcode:  horz_leg ? OP_MOVE_FF : OP_MOVE,
                      heading: leg_hdg,
                      squares: leg_sq};

  ////////////////////
  // Command path.
  ////////////////////
  assign cmd_control  = (state != IDLE);
  assign cmd          = cmd_control ? cmd_tour : cmd_uart;
  assign cmd_rdy      = cmd_control ? cmd_rdy_tour : cmd_rdy_uart;
  assign clr_cmd_uart = clr_cmd_rdy & ~cmd_control; // A queued host command survives the tour.
  assign resp         = (tour_done && !cmd_control) ? RESP_DONE : RESP_BUSY;

  ////////////////////
  // Replay FSM.
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state    = state;
    clr_index    = 1'b0;
    inc_index    = 1'b0;
    cmd_rdy_tour = 1'b0;
    case (state)
      VERT: begin
        cmd_rdy_tour = 1'b1;            // Offer the vertical leg.
        if (clr_cmd_rdy) nxt_state = HOLDV;
      end
      HOLDV: begin
        if (send_resp) nxt_state = HORZ; // Vertical leg done.
      end
      HORZ: begin
        cmd_rdy_tour = 1'b1;            // Offer the horizontal leg.
        if (clr_cmd_rdy) nxt_state = HOLDH;
      end
      HOLDH: begin
        if (send_resp) begin
          if (tour_done) begin
            nxt_state = IDLE;           // Hand the path back to the host.
          end else begin
            inc_index = 1'b1;
            nxt_state = VERT;
          end
        end
      end
      default: begin                    // IDLE, host owns the path.
        if (start_tour) begin
          clr_index = 1'b1;
          nxt_state = VERT;
        end
      end
    endcase
  end

endmodule

// ==== rtl/move_exec.sv ====
`timescale 1ns/1ps

module move_exec #(
  parameter  int STEP_CYCLES = 4,
  localparam int TMR_W       = $clog2(STEP_CYCLES + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  knight_pkg::cmd_t   cmd,         // Command to run.
  input  logic               cmd_rdy,     // Command waiting.
  output logic               clr_cmd_rdy, // Pulse, command taken.
  output logic               send_resp,   // Pulse, command finished.
  output logic               fanfare,     // Pulse at the end of a fanfare move.
  output knight_pkg::coord_t pos_x,       // Column, east is up.
  output knight_pkg::coord_t pos_y        // Row, north is up.
);

  import knight_pkg::*;

  typedef enum logic [1:0] {IDLE, STEP, RESP} state_t;

  state_t           state;     // Current state.
  opcode_t          op_q;      // Opcode of the running command.
  heading_t         hdg_q;     // Heading of the running command.
  sq_cnt_t          sq_left;   // Squares still to travel.
  logic [TMR_W-1:0] tmr;       // Cycles spent on this square.
  logic             take;      // Capture the offered command.
  logic             is_move;   // Offered command travels.
  logic             step_now;  // One square done this cycle.
  logic             last_step; // Final square done this cycle.
  logic             dir_n;
  logic             dir_s;
  logic             dir_e;
  logic             dir_w;

  ////////////////////
  // Handshake.
  ////////////////////
  assign take        = (state == IDLE) && cmd_rdy;
  assign clr_cmd_rdy = take;                                  // Same cycle as cmd_rdy.
  assign is_move     = (cmd.opcode == OP_MOVE) || (cmd.opcode == OP_MOVE_FF);
  assign send_resp   = (state == RESP);
  assign fanfare     = send_resp && (op_q == OP_MOVE_FF);

  // Step timing.
  assign step_now  = (state == STEP) && (tmr == TMR_W'(STEP_CYCLES - 1));
  assign last_step = step_now && (sq_left == 4'd1);

  // Heading decode, anything unknown does not move.
  assign dir_n = (hdg_q == HDG_NORTH);
  assign dir_s = (hdg_q == HDG_SOUTH);
  assign dir_e = (hdg_q == HDG_EAST);
  assign dir_w = (hdg_q == HDG_WEST);

  ////////////////////
  // Control.
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sq_left <= '0;
      tmr     <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            sq_left <= cmd.squares;
            tmr     <= '0;
            state   <= (is_move && cmd.squares != 4'd0) ? STEP : RESP; // Nothing to time.
          end
        end
        STEP: begin
          if (step_now) begin
            tmr     <= '0;
            sq_left <= sq_left - 1'b1;
          end else begin
            tmr <= tmr + 1'b1;
          end
          if (last_step) state <= RESP; // Respond on the next cycle.
        end
        default: state <= IDLE;         // RESP lasts one cycle.
      endcase
    end
  end

  // Command fields, held until the next capture.
  always_ff @(posedge clk) begin
    if (take) begin
      op_q  <= cmd.opcode;
      hdg_q <= cmd.heading;
    end
  end

  ////////////////////
  // Board position.
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pos_x <= HOME_COORD; // Start on the centre square.
      pos_y <= HOME_COORD;
    end else if (take && cmd.opcode == OP_HOME) begin
      pos_x <= HOME_COORD;
      pos_y <= HOME_COORD;
    end else if (step_now) begin
      if (dir_n && pos_y != BOARD_MAX) pos_y <= pos_y + 1'b1; // Stop at the edge.
      if (dir_s && pos_y != '0)        pos_y <= pos_y - 1'b1;
      if (dir_e && pos_x != BOARD_MAX) pos_x <= pos_x + 1'b1;
      if (dir_w && pos_x != '0)        pos_x <= pos_x - 1'b1;
    end
  end

endmodule

// ==== rtl/knight_top.sv ====
`timescale 1ns/1ps

module knight_top #(
  parameter  int NUM_MOVES   = 24,
  parameter  int STEP_CYCLES = 4,
  localparam int IDX_W       = $clog2(NUM_MOVES)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  knight_pkg::cmd_t   host_cmd,     // Host command word.
  input  logic               host_cmd_vld, // Pulse with host_cmd.
  input  logic               mv_wr_en,     // Tour load strobe.
  input  logic [IDX_W-1:0]   mv_wr_addr,
  input  knight_pkg::move_t  mv_wr_data,
  input  logic               start_tour,   // Pulse, replay the tour.
  output knight_pkg::resp_t  resp,         // Valid with resp_vld.
  output logic               resp_vld,     // Pulse per finished command.
  output knight_pkg::coord_t pos_x,
  output knight_pkg::coord_t pos_y,
  output logic               fanfare       // Pulse after each full L.
);

  import knight_pkg::*;

  cmd_t             cmd_uart;     // Held host command.
  logic             cmd_rdy_uart; // Host command pending.
  logic             clr_cmd_uart; // Clear for the host register.
  cmd_t             cmd;          // Muxed command to the executor.
  logic             cmd_rdy;      // Muxed ready level.
  logic             clr_cmd_rdy;  // Executor took the command.
  logic [IDX_W-1:0] mv_indx;      // Tour read index.
  move_t            move;         // Move at mv_indx.

  move_store #(.NUM_MOVES(NUM_MOVES)) u_store (
    .clk(clk), .rst_n(rst_n),
    .wr_en(mv_wr_en), .wr_addr(mv_wr_addr), .wr_data(mv_wr_data),
    .mv_indx(mv_indx), .move(move)
  );

  host_cmd_reg u_host (
    .clk(clk), .rst_n(rst_n),
    .host_cmd(host_cmd), .host_cmd_vld(host_cmd_vld),
    .clr_cmd_rdy(clr_cmd_uart), .cmd_uart(cmd_uart), .cmd_rdy_uart(cmd_rdy_uart)
  );

  tour_cmd #(.NUM_MOVES(NUM_MOVES)) u_tour (
    .clk(clk), .rst_n(rst_n), .start_tour(start_tour),
    .move(move), .mv_indx(mv_indx),
    .cmd_uart(cmd_uart), .cmd_rdy_uart(cmd_rdy_uart),
    .cmd(cmd), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
    .clr_cmd_uart(clr_cmd_uart), .send_resp(resp_vld), .resp(resp)
  );

  move_exec #(.STEP_CYCLES(STEP_CYCLES)) u_exec (
    .clk(clk), .rst_n(rst_n),
    .cmd(cmd), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
    .send_resp(resp_vld), .fanfare(fanfare),
    .pos_x(pos_x), .pos_y(pos_y)
  );

endmodule

// ==== tb/tb_knight_top.sv ====
`timescale 1ns/1ps

module tb_knight_top;

  import knight_pkg::*;

  localparam int NUM_MOVES   = 24;
  localparam int STEP_CYCLES = 4;
  localparam int IDX_W       = $clog2(NUM_MOVES);
  localparam int MAX_EXP     = 256; // Room for every response of the run.

  logic             clk;
  logic             rst_n;
  cmd_t             host_cmd;
  logic             host_cmd_vld;
  logic             mv_wr_en;
  logic [IDX_W-1:0] mv_wr_addr;
  move_t            mv_wr_data;
  logic             start_tour;
  resp_t            resp;
  logic             resp_vld;
  coord_t           pos_x;
  coord_t           pos_y;
  logic             fanfare;

  ////////////////////
  // Expected responses, in arrival order.
  ////////////////////
  int    exp_x    [MAX_EXP];
  int    exp_y    [MAX_EXP];
  resp_t exp_resp [MAX_EXP];
  bit    exp_ff   [MAX_EXP];
  bit    exp_lat  [MAX_EXP]; // Latency known for this one.
  int    exp_cyc  [MAX_EXP]; // Cycle count seen during resp_vld.
  int    exp_cnt;            // Entries pushed so far.
  int    resp_cnt;           // Responses seen so far.
  int    cyc;                // Free running cycle count.
  int    cur_x;
  int    cur_y;
  int    cur_cyc;
  resp_t cur_resp;
  bit    cur_ff;
  bit    cur_lat;

  // Reference model state.
  int     mdl_x;
  int     mdl_y;
  bit     tour_seen;          // A tour has finished, host answers turn to RESP_DONE.
  int     tour_idx [NUM_MOVES]; // Bit index of each stored move.
  integer seed;
  int     err_cnt;
  int     tmo_cnt;
  string  test_name;

  knight_top #(.NUM_MOVES(NUM_MOVES), .STEP_CYCLES(STEP_CYCLES)) uut (
    .clk(clk), .rst_n(rst_n),
    .host_cmd(host_cmd), .host_cmd_vld(host_cmd_vld),
    .mv_wr_en(mv_wr_en), .mv_wr_addr(mv_wr_addr), .mv_wr_data(mv_wr_data),
    .start_tour(start_tour), .resp(resp), .resp_vld(resp_vld),
    .pos_x(pos_x), .pos_y(pos_y), .fanfare(fanfare)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period.

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_cnt <= 0;
      cyc      <= 0;
    end else begin
      cyc <= cyc + 1;
      if (resp_vld) resp_cnt <= resp_cnt + 1; // One per finished command.
    end
  end

  // Entry that the next response must match.
  assign cur_x    = exp_x[resp_cnt % MAX_EXP];
  assign cur_y    = exp_y[resp_cnt % MAX_EXP];
  assign cur_resp = exp_resp[resp_cnt % MAX_EXP];
  assign cur_ff   = exp_ff[resp_cnt % MAX_EXP];
  assign cur_lat  = exp_lat[resp_cnt % MAX_EXP];
  assign cur_cyc  = exp_cyc[resp_cnt % MAX_EXP];

  ////////////////////
  // Response checks.
  ////////////////////
  a_extra: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> resp_cnt < exp_cnt)
    else begin
      err_cnt++;
      $display("Error in %s: a response came with none outstanding", test_name);
    end
  a_pos_x: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> pos_x == cur_x)
    else begin
      err_cnt++;
      $display("Fail %s pos_x: expected %0d, actual %0d", test_name, $sampled(cur_x),
               $sampled(pos_x));
    end
  a_pos_y: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> pos_y == cur_y)
    else begin
      err_cnt++;
      $display("Fail %s pos_y: expected %0d, actual %0d", test_name, $sampled(cur_y),
               $sampled(pos_y));
    end
  a_resp: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> resp == cur_resp)
    else begin
      err_cnt++;
      $display("Fail %s resp: expected %h, actual %h", test_name, $sampled(cur_resp),
               $sampled(resp));
    end
  a_ff: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> fanfare == cur_ff)
    else begin
      err_cnt++;
      $display("Fail %s fanfare: expected %0d, actual %0d", test_name, $sampled(cur_ff),
               $sampled(fanfare));
    end
  a_ff_only: assert property (@(posedge clk) disable iff (!rst_n) fanfare |-> resp_vld)
    else begin
      err_cnt++;
      $display("Error in %s: fanfare pulsed without a response", test_name);
    end
  a_lat: assert property (@(posedge clk) disable iff (!rst_n)
                          resp_vld && cur_lat |-> cyc == cur_cyc)
    else begin
      err_cnt++;
      $display("Fail %s latency: expected cycle %0d, actual %0d", test_name,
               $sampled(cur_cyc), $sampled(cyc));
    end

  ////////////////////
  // Model helpers.
  ////////////////////
  function automatic int clamp(input int v);
    if (v < 0) return 0;
    if (v > BOARD_MAX) return BOARD_MAX; // Board edge.
    return v;
  endfunction

  // Vertical leg of each one-hot bit, north positive.
  function automatic int vert_delta(input int idx);
    case (idx)
      0, 1:    return 2;
      2, 7:    return 1;
      3, 6:    return -1;
      default: return -2;
    endcase
  endfunction

  // Horizontal leg, east positive.
  function automatic int horz_delta(input int idx);
    case (idx)
      0, 5:    return 1;
      1, 4:    return -1;
      2, 3:    return -2;
      default: return 2;
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #1; // Drive and sample away from the edge.
  endtask

  task automatic check_val(input string what, input int expv, input int actv);
    assert (actv == expv) else begin
      err_cnt++;
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expv, actv);
    end
  endtask

  task automatic push_exp(input resp_t r, input bit ff, input bit lat, input int c);
    exp_x[exp_cnt]    = mdl_x;
    exp_y[exp_cnt]    = mdl_y;
    exp_resp[exp_cnt] = r;
    exp_ff[exp_cnt]   = ff;
    exp_lat[exp_cnt]  = lat;
    exp_cyc[exp_cnt]  = c;
    exp_cnt++;
  endtask

  task automatic wait_resps(input int target, input int limit);
    int n;
    n = 0;
    while (resp_cnt < target && n < limit) begin
      tick();
      n++;
    end
    if (resp_cnt < target) begin
      tmo_cnt++;
      $display("Timeout in %s: %0d of %0d responses after %0d cycles", test_name,
               resp_cnt, target, limit);
    end
  endtask

  // Model first, then one strobe on the host port.
  task automatic host_send(input opcode_t op, input heading_t hdg, input int sq,
                           input bit lat_on);
    int lat;
    lat = 2;
    if (op == OP_HOME) begin
      mdl_x = HOME_COORD;
      mdl_y = HOME_COORD;
    end else if (op == OP_MOVE) begin
      lat = 2 + sq * STEP_CYCLES;
      case (hdg)
        HDG_NORTH: mdl_y = clamp(mdl_y + sq);
        HDG_SOUTH: mdl_y = clamp(mdl_y - sq);
        HDG_EAST:  mdl_x = clamp(mdl_x + sq);
        default:   mdl_x = clamp(mdl_x - sq);
      endcase
    end
    tick();
    push_exp(tour_seen ? RESP_DONE : RESP_BUSY, 1'b0, lat_on, cyc + lat);
    host_cmd     = '{opcode: op, heading: hdg, squares: sq_cnt_t'(sq)};
    host_cmd_vld = 1'b1;
    tick();
    host_cmd_vld = 1'b0;
  endtask

  task automatic load_tour();
    for (int i = 0; i < NUM_MOVES; i++) begin
      tour_idx[i] = $unsigned($random(seed)) % 8;
      tick();
      mv_wr_en   = 1'b1;
      mv_wr_addr = IDX_W'(i);
      mv_wr_data = move_t'(8'h01 << tour_idx[i]);
    end
    tick();
    mv_wr_en = 1'b0;
  endtask

  // Vertical leg then horizontal leg with fanfare, two responses per move.
  task automatic expect_tour();
    for (int i = 0; i < NUM_MOVES; i++) begin
      mdl_y = clamp(mdl_y + vert_delta(tour_idx[i]));
      push_exp(RESP_BUSY, 1'b0, 1'b0, 0);
      mdl_x = clamp(mdl_x + horz_delta(tour_idx[i]));
      push_exp(RESP_BUSY, 1'b1, 1'b0, 0);
    end
    tour_seen = 1'b1;
  endtask

  task automatic pulse_start();
    tick();
    start_tour = 1'b1;
    tick();
    start_tour = 1'b0;
  endtask

  ////////////////////
  // Test sequence.
  ////////////////////
  initial begin
    int       pick;
    heading_t hdg;
    seed         = 32'hf13cbc1d;
    err_cnt      = 0;
    tmo_cnt      = 0;
    exp_cnt      = 0;
    tour_seen    = 1'b0;
    mdl_x        = HOME_COORD;
    mdl_y        = HOME_COORD;
    test_name    = "reset";
    rst_n        = 1'b0;
    host_cmd     = '0;
    host_cmd_vld = 1'b0;
    mv_wr_en     = 1'b0;
    mv_wr_addr   = '0;
    mv_wr_data   = '0;
    start_tour   = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    tick();
    check_val("resp_vld", 0, resp_vld);
    check_val("fanfare", 0, fanfare);
    check_val("pos_x", HOME_COORD, pos_x);
    check_val("pos_y", HOME_COORD, pos_y);

    test_name = "host_move";
    for (int i = 0; i < 12; i++) begin
      pick = $unsigned($random(seed)) % 4;
      case (pick)
        0:       hdg = HDG_NORTH;
        1:       hdg = HDG_WEST;
        2:       hdg = HDG_SOUTH;
        default: hdg = HDG_EAST;
      endcase
      host_send(OP_MOVE, hdg, $unsigned($random(seed)) % 4, 1'b1);
      wait_resps(exp_cnt, 100);
    end

    test_name = "home";
    host_send(OP_HOME, HDG_EAST, 3, 1'b1);
    wait_resps(exp_cnt, 100);

    test_name = "tour";
    load_tour();
    expect_tour();
    pulse_start();
    wait_resps(exp_cnt, 2000);
    check_val("resp after tour", RESP_DONE, resp);

    // Host strobe a few legs in, it must wait for the tour to end.
    test_name = "tour_hold";
    expect_tour();
    pulse_start();
    wait_resps(exp_cnt - 45, 500);
    host_send(OP_MOVE, HDG_SOUTH, 2, 1'b0);
    wait_resps(exp_cnt, 2000);

    test_name = "tour_again";
    expect_tour();
    pulse_start();
    wait_resps(exp_cnt, 2000);
    check_val("resp after tour", RESP_DONE, resp);

    // Quiet tail catches stray responses.
    test_name = "idle";
    for (int i = 0; i < 40; i++) begin
      tick();
    end
    check_val("response count", exp_cnt, resp_cnt);

    $display("Done: %0d responses, %0d errors, %0d timeouts", resp_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== knight.f ====
rtl/knight_pkg.sv
rtl/move_store.sv
rtl/host_cmd_reg.sv
rtl/tour_cmd.sv
rtl/move_exec.sv
rtl/knight_top.sv
tb/tb_knight_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f knight.f \
  --top-module tb_knight_top -o sim_knight > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_knight > sim.log 2>&1 && cat sim.log \
  || { cat sim.log; echo "Simulator exited with an error"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "No pass line in the log"; exit 1; }
exit 0
